// ==== hw/tileMemPkg.sv ====
package tileMemPkg;

   // ============================================================
   // Widths and address map
   // ============================================================
   localparam int wordW       = 32;
   localparam int tileIdW     = 8;      // Address bits 31:24
   localparam int iMemAdrsMsb = 11;     // 1K words
   localparam int dMemAdrsMsb = 11;     // 1K words
   localparam int regionMsb   = 23;
   localparam int regionLsb   = 16;

   // Region field ranges, floor inclusive, roof exclusive
   localparam logic [7:0] iMemRegionFloor = 8'h00;
   localparam logic [7:0] iMemRegionRoof  = 8'h01;
   localparam logic [7:0] dMemRegionFloor = 8'h01;
   localparam logic [7:0] dMemRegionRoof  = 8'h02;

   localparam int fifoDepth = 2;        // Per outgoing queue

   // ============================================================
   // Fabric transaction
   // ============================================================
   typedef enum logic [1:0] {
      rd    = 2'b00,
      wr    = 2'b01,
      rdRsp = 2'b10
   } tOpcode;

   typedef struct packed {
      logic [wordW-1:0]   address;
      logic [wordW-1:0]   data;
      tOpcode             opcode;
      logic [tileIdW-1:0] requestorId; // Sender tile
   } tTileTrans;

endpackage

// ==== hw/dualPortRam.sv ====
module dualPortRam #(
   parameter int adrsW = 10
) (
   input  logic                         Clock,
   // Port A, byte writes
   input  logic [adrsW-1:0]             addrA,
   input  logic [tileMemPkg::wordW-1:0] dataA,
   input  logic                         wrEnA,
   input  logic [3:0]                   byteEnA,
   output logic [tileMemPkg::wordW-1:0] qA,
   // Port B, whole words
   input  logic [adrsW-1:0]             addrB,
   input  logic [tileMemPkg::wordW-1:0] dataB,
   input  logic                         wrEnB,
   output logic [tileMemPkg::wordW-1:0] qB
);

   logic [tileMemPkg::wordW-1:0] mem [2**adrsW];

   // Both ports share one array, read data registered
   always_ff @(posedge Clock) begin
      for (int i = 0; i < 4; i++) begin
         if (wrEnA && byteEnA[i]) begin
            mem[addrA][8*i +: 8] <= dataA[8*i +: 8]; // Lane i only
         end
      end
      if (wrEnB) begin
         mem[addrB] <= dataB;
      end
      qA <= mem[addrA];  // Old data on collision
      qB <= mem[addrB];
   end

endmodule

// ==== hw/transFifo.sv ====
module transFifo #(
   parameter int depth = tileMemPkg::fifoDepth
) (
   input  logic                  Clock,
   input  logic                  rstN,
   input  logic                  push,
   input  tileMemPkg::tTileTrans pushData,
   input  logic                  pop,
   output tileMemPkg::tTileTrans popData,
   output logic                  full,
   output logic                  almostFull,
   output logic                  empty
);

   tileMemPkg::tTileTrans        entries [depth];
   logic [$clog2(depth)-1:0]     wrPtr;
   logic [$clog2(depth)-1:0]     rdPtr;
   logic [$clog2(depth+1)-1:0]   count;
   logic                         doPush;
   logic                         doPop;

   assign doPush = push && !full;    // Overflow dropped
   assign doPop  = pop && !empty;

   // Pointers and occupancy
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) wrPtr <= (wrPtr == ($clog2(depth))'(depth-1)) ? '0 : wrPtr + 1'b1;
         if (doPop)  rdPtr <= (rdPtr == ($clog2(depth))'(depth-1)) ? '0 : rdPtr + 1'b1;
         count <= count + doPush - doPop;
      end
   end

   always_ff @(posedge Clock) begin
      if (doPush) entries[wrPtr] <= pushData;
   end

   assign popData    = entries[rdPtr];  // Head visible before pop
   assign full       = (count == ($clog2(depth+1))'(depth));
   assign almostFull = (count >= ($clog2(depth+1))'(depth-1)); // One slot or none left
   assign empty      = (count == '0);

endmodule

// ==== hw/rrArbiter.sv ====
module rrArbiter (
   input  logic       Clock,
   input  logic       rstN,
   input  logic [1:0] request,
   output logic [1:0] grant
);

   logic lastWasZero;  // Client 1 first when set

   // ============================================================
   // Grant, favoured client wins ties
   // ============================================================
   always_comb begin
      if (lastWasZero) begin
         grant[1] = request[1];
         grant[0] = request[0] && !request[1];
      end else begin
         grant[0] = request[0];
         grant[1] = request[1] && !request[0];
      end
   end

   // Priority moves past each winner
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         lastWasZero <= 1'b0;  // Response queue first
      end else if (grant[0]) begin
         lastWasZero <= 1'b1;
      end else if (grant[1]) begin
         lastWasZero <= 1'b0;
      end
   end

endmodule

// ==== hw/fabricTarget.sv ====
module fabricTarget (
   input  logic                         Clock,
   input  logic                         rstN,
   input  logic [7:0]                   localTileId,
   input  logic                         inFabricValid,
   input  tileMemPkg::tTileTrans        inFabric,
   output logic                         iMemWrEn,
   output logic                         dMemWrEn,
   input  logic [tileMemPkg::wordW-1:0] iMemRdData,
   input  logic [tileMemPkg::wordW-1:0] dMemRdData,
   output logic                         rspValid,
   output tileMemPkg::tTileTrans        rspTrans
);

   logic [7:0]                   regionQ503H;
   logic                         iMemHitQ503H;
   logic                         dMemHitQ503H;
   logic                         iMemHitQ504H;
   logic                         dMemHitQ504H;
   logic [tileMemPkg::wordW-1:0] rspAddressQ504H;
   logic [7:0]                   rspTileIdQ504H;

   // ============================================================
   // Region decode, Q503
   // ============================================================
   assign regionQ503H  = inFabric.address[tileMemPkg::regionMsb:tileMemPkg::regionLsb];
   assign iMemHitQ503H = (regionQ503H >= tileMemPkg::iMemRegionFloor) &&
                         (regionQ503H <  tileMemPkg::iMemRegionRoof);
   assign dMemHitQ503H = (regionQ503H >= tileMemPkg::dMemRegionFloor) &&
                         (regionQ503H <  tileMemPkg::dMemRegionRoof);
   assign iMemWrEn = iMemHitQ503H && inFabricValid && (inFabric.opcode == tileMemPkg::wr);
   assign dMemWrEn = dMemHitQ503H && inFabricValid && (inFabric.opcode == tileMemPkg::wr);

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         rspValid     <= 1'b0;
         iMemHitQ504H <= 1'b0;
         dMemHitQ504H <= 1'b0;
      end else begin
         rspValid     <= inFabricValid && (inFabric.opcode == tileMemPkg::rd);
         iMemHitQ504H <= iMemHitQ503H;
         dMemHitQ504H <= dMemHitQ503H;
      end
   end

   // Response header, routed back to requestor
   always_ff @(posedge Clock) begin
      rspAddressQ504H <= {inFabric.requestorId, inFabric.address[tileMemPkg::regionMsb:0]};
      rspTileIdQ504H  <= localTileId;
   end

   // Q504 response, RAM word arrives now
   always_comb begin
      rspTrans.address     = rspAddressQ504H;
      rspTrans.opcode      = tileMemPkg::rdRsp;
      rspTrans.requestorId = rspTileIdQ504H;
      rspTrans.data        = iMemHitQ504H ? iMemRdData :
                             dMemHitQ504H ? dMemRdData : '0;  // Unmapped reads zero
   end

endmodule

// ==== hw/coreDataPort.sv ====
module coreDataPort (
   input  logic                         Clock,
   input  logic                         rstN,
   input  logic [7:0]                   localTileId,
   // Core side
   input  logic [tileMemPkg::wordW-1:0] dMemAddressQ103H,
   input  logic [tileMemPkg::wordW-1:0] dMemWrDataQ103H,
   input  logic [3:0]                   dMemByteEnQ103H,
   input  logic                         dMemWrEnQ103H,
   input  logic                         dMemRdEnQ103H,
   // Local RAM port A
   output logic [tileMemPkg::wordW-1:0] ramWrData,
   output logic [3:0]                   ramByteEn,
   output logic                         ramWrEn,
   input  logic [tileMemPkg::wordW-1:0] ramRdData,
   // Fabric
   input  logic                         inFabricValid,
   input  tileMemPkg::tTileTrans        inFabric,
   output logic                         reqValid,
   output tileMemPkg::tTileTrans        reqTrans,
   input  logic                         reqFull,
   output logic                         dMemReady,
   output logic [tileMemPkg::wordW-1:0] dMemRdRspQ105H
);

   logic [tileMemPkg::tileIdW-1:0] tileIdQ103H;
   logic                           isLocalQ103H;
   logic [1:0]                     offsetQ103H;
   logic [1:0]                     offsetQ104H;
   logic                           outstandingRd;
   logic                           fabRspHitQ503H;
   logic                           fabRspValidQ504H;
   logic [tileMemPkg::wordW-1:0]   fabRspDataQ504H;
   logic                           readyQ104H;
   logic [tileMemPkg::wordW-1:0]   lastRamQ104H;
   logic [tileMemPkg::wordW-1:0]   ramHeldQ104H;
   logic [tileMemPkg::wordW-1:0]   loadQ104H;

   // ============================================================
   // Q103 decode and store alignment
   // ============================================================
   assign tileIdQ103H  = dMemAddressQ103H[tileMemPkg::wordW-1 -: tileMemPkg::tileIdW];
   assign isLocalQ103H = (tileIdQ103H == '0) || (tileIdQ103H == localTileId);
   assign offsetQ103H  = dMemAddressQ103H[1:0];
   assign ramWrData    = dMemWrDataQ103H << {offsetQ103H, 3'b000};
   assign ramByteEn    = dMemByteEnQ103H << offsetQ103H;
   assign ramWrEn      = dMemWrEnQ103H && isLocalQ103H;

   // Remote access, one read in flight at most
   assign reqValid = (dMemWrEnQ103H || dMemRdEnQ103H) && !isLocalQ103H && !outstandingRd;
   always_comb begin
      reqTrans.address     = dMemAddressQ103H;
      reqTrans.data        = dMemWrDataQ103H;
      reqTrans.requestorId = localTileId;
      if (dMemWrEnQ103H) reqTrans.opcode = tileMemPkg::wr;
      else               reqTrans.opcode = tileMemPkg::rd;
   end

   assign fabRspHitQ503H = outstandingRd && inFabricValid &&
                           (inFabric.opcode == tileMemPkg::rdRsp);
   assign dMemReady      = !outstandingRd && !reqFull;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         outstandingRd    <= 1'b0;
         fabRspValidQ504H <= 1'b0;
         readyQ104H       <= 1'b1;
      end else begin
         if (fabRspHitQ503H)                           outstandingRd <= 1'b0; // Stall ends
         else if (dMemRdEnQ103H && !isLocalQ103H)      outstandingRd <= 1'b1;
         fabRspValidQ504H <= fabRspHitQ503H;
         readyQ104H       <= dMemReady;
      end
   end

   // ============================================================
   // Q104 load path
   // ============================================================
   always_ff @(posedge Clock) begin
      fabRspDataQ504H <= inFabric.data;
      if (dMemReady)  offsetQ104H  <= offsetQ103H;
      if (readyQ104H) lastRamQ104H <= ramRdData;   // Word kept over a stall
      if (dMemReady)  dMemRdRspQ105H <= loadQ104H; // Second cycle of latency
   end

   assign ramHeldQ104H = readyQ104H ? ramRdData : lastRamQ104H;
   assign loadQ104H    = fabRspValidQ504H ? fabRspDataQ504H :
                         ramHeldQ104H >> {offsetQ104H, 3'b000}; // Zero filled from top

endmodule

// ==== hw/tileMemWrap.sv ====
module tileMemWrap (
   input  logic                         Clock,
   input  logic                         rstN,
   input  logic [7:0]                   localTileId,
   // Core fetch
   input  logic                         readyQ101H,
   input  logic [tileMemPkg::wordW-1:0] pcQ100H,
   output logic [tileMemPkg::wordW-1:0] instructionQ101H,
   // Core data
   input  logic [tileMemPkg::wordW-1:0] dMemAddressQ103H,
   input  logic [tileMemPkg::wordW-1:0] dMemWrDataQ103H,
   input  logic [3:0]                   dMemByteEnQ103H,
   input  logic                         dMemWrEnQ103H,
   input  logic                         dMemRdEnQ103H,
   output logic                         dMemReady,
   output logic [tileMemPkg::wordW-1:0] dMemRdRspQ105H,
   // Fabric
   input  logic                         inFabricValid,
   input  tileMemPkg::tTileTrans        inFabric,
   output logic                         tileReady,
   output logic                         outFabricValid,
   output tileMemPkg::tTileTrans        outFabric,
   input  logic                         fabReady
);

   logic [tileMemPkg::wordW-1:0] instrRawQ101H;
   logic [tileMemPkg::wordW-1:0] lastInstrQ101H;
   logic                         sampleReadyQ101H;
   logic                         iMemWrEn;
   logic                         dMemWrEn;
   logic [tileMemPkg::wordW-1:0] iMemRdData;
   logic [tileMemPkg::wordW-1:0] dMemRdData;
   logic [tileMemPkg::wordW-1:0] ramWrData;
   logic [3:0]                   ramByteEn;
   logic                         ramWrEn;
   logic [tileMemPkg::wordW-1:0] ramRdData;
   logic                         rspValid;
   tileMemPkg::tTileTrans        rspTrans;
   tileMemPkg::tTileTrans        rspHead;
   logic                         rspAlmostFull;
   logic                         rspEmpty;
   logic                         reqValid;
   tileMemPkg::tTileTrans        reqTrans;
   tileMemPkg::tTileTrans        reqHead;
   logic                         reqFull;
   logic                         reqEmpty;
   logic [1:0]                   grant;     // [0] responses, [1] requests

   // ============================================================
   // Memories, core on A and fabric on B
   // ============================================================
   dualPortRam #(.adrsW(tileMemPkg::iMemAdrsMsb - 1)) iMem (
      .Clock (Clock),
      .addrA (pcQ100H[tileMemPkg::iMemAdrsMsb:2]), .dataA ('0), .wrEnA (1'b0),
      .byteEnA (4'b0000), .qA (instrRawQ101H),
      .addrB (inFabric.address[tileMemPkg::iMemAdrsMsb:2]), .dataB (inFabric.data),
      .wrEnB (iMemWrEn), .qB (iMemRdData)
   );

   dualPortRam #(.adrsW(tileMemPkg::dMemAdrsMsb - 1)) dMem (
      .Clock (Clock),
      .addrA (dMemAddressQ103H[tileMemPkg::dMemAdrsMsb:2]), .dataA (ramWrData),
      .wrEnA (ramWrEn), .byteEnA (ramByteEn), .qA (ramRdData),
      .addrB (inFabric.address[tileMemPkg::dMemAdrsMsb:2]), .dataB (inFabric.data),
      .wrEnB (dMemWrEn), .qB (dMemRdData)
   );

   // Fetch hold while core stalled
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) sampleReadyQ101H <= 1'b1;
      else       sampleReadyQ101H <= readyQ101H;
   end
   always_ff @(posedge Clock) begin
      if (sampleReadyQ101H) lastInstrQ101H <= instrRawQ101H;
   end
   assign instructionQ101H = sampleReadyQ101H ? instrRawQ101H : lastInstrQ101H;

   fabricTarget u_fabricTarget (.*);
   coreDataPort u_coreDataPort (.*);

   // ============================================================
   // Outgoing queues sharing one fabric bus
   // ============================================================
   transFifo rspFifo (
      .Clock (Clock), .rstN (rstN), .push (rspValid), .pushData (rspTrans),
      .pop (grant[0]), .popData (rspHead), .full (),
      .almostFull (rspAlmostFull), .empty (rspEmpty)
   );
   transFifo reqFifo (
      .Clock (Clock), .rstN (rstN), .push (reqValid), .pushData (reqTrans),
      .pop (grant[1]), .popData (reqHead), .full (reqFull),
      .almostFull (), .empty (reqEmpty)
   );

   rrArbiter u_rrArbiter (
      .Clock   (Clock),
      .rstN    (rstN),
      .request ({!reqEmpty && fabReady, !rspEmpty && fabReady}), // Nothing moves without ready
      .grant   (grant)
   );

   assign outFabricValid = |grant;
   assign outFabric      = grant[0] ? rspHead :
                           grant[1] ? reqHead : '0;
   assign tileReady      = !rspAlmostFull;   // Margin for the flag delay

endmodule

// ==== testbench/tileMem_checker.sv ====
module tileMem_checker (
   input logic                         Clock,
   input logic                         rstN,
   input logic [7:0]                   localTileId,
   input logic [tileMemPkg::wordW-1:0] dMemAddressQ103H,
   input logic                         dMemRdEnQ103H,
   input logic                         dMemReady,
   input logic                         outFabricValid,
   input logic                         fabReady
);

   logic [tileMemPkg::tileIdW-1:0] tileId;
   logic                           remoteRd;   // Accepted read to a foreign tile

   assign tileId   = dMemAddressQ103H[tileMemPkg::wordW-1 -: tileMemPkg::tileIdW];
   assign remoteRd = dMemRdEnQ103H && dMemReady && (tileId != '0) && (tileId != localTileId);

   // ============================================================
   // Handshake properties
   // ============================================================
   validNeedsReady: assert property (@(posedge Clock) disable iff (!rstN)
      outFabricValid |-> fabReady)
      else $error("outFabricValid high without fabReady");

   stallAfterRemoteRd: assert property (@(posedge Clock) disable iff (!rstN)
      remoteRd |=> !dMemReady)                  // Stall starts next cycle
      else $error("dMemReady still high after a remote read");

   quietAfterReset: assert property (@(posedge Clock) $rose(rstN) |-> !outFabricValid)
      else $error("outFabricValid high right after reset");

endmodule

// ==== testbench/tileMemTb.sv ====
module tileMemTb;

   typedef enum logic [2:0] {kSt, kFabWr, kFetch, kFabRd, kRemSt, kRemLd, kBurst} tKind;
   typedef struct packed {
      tKind        kind;
      logic [31:0] addr;
      logic [31:0] data;   // Burst length for kBurst
      logic [3:0]  be;
      logic [31:0] exp;    // Load-back value after a store
   } tStep;

   localparam int         nSteps = 17;
   localparam logic [7:0] myId   = 8'h05;
   localparam logic [7:0] peerId = 8'h3c;  // Requestor of fabric reads

   logic                  Clock, rstN, readyQ101H, dMemWrEnQ103H, dMemRdEnQ103H;
   logic                  inFabricValid, fabReady, dMemReady, tileReady, outFabricValid;
   logic [7:0]            localTileId;
   logic [3:0]            dMemByteEnQ103H;
   logic [31:0]           pcQ100H, instructionQ101H, dMemAddressQ103H, dMemWrDataQ103H;
   logic [31:0]           dMemRdRspQ105H;
   tileMemPkg::tTileTrans inFabric, outFabric;
   tileMemPkg::tTileTrans seen [$];        // Everything accepted on outFabric
   logic [7:0]            dModel [4096];   // Data memory, byte lanes
   logic [31:0]           iModel [1024];

   tStep steps [nSteps] = '{
      '{kSt,    32'h0000_0100, 32'h1122_3344, 4'hf, 32'h1122_3344},
      '{kSt,    32'h0000_0101, 32'h0000_00aa, 4'h1, 32'h0011_22aa},
      '{kSt,    32'h0000_0102, 32'h0000_beef, 4'h3, 32'h0000_beef},
      '{kSt,    32'h0000_0103, 32'h0000_0055, 4'h1, 32'h0000_0055},
      '{kSt,    32'h0000_0100, 32'h0000_0077, 4'h1, 32'h55ef_aa77},
      '{kSt,    32'h0000_0101, 32'h0000_1234, 4'h3, 32'h0055_1234},  // Half across lanes 1,2
      '{kFabWr, 32'h0000_0040, 32'hcafe_0013, 4'h0, 32'h0},
      '{kFabWr, 32'h0000_0044, 32'h00a0_0093, 4'h0, 32'h0},
      '{kFetch, 32'h0000_0040, 32'h0,         4'h0, 32'h0},
      '{kFetch, 32'h0000_0044, 32'h0,         4'h0, 32'h0},
      '{kFabWr, 32'h0001_0200, 32'h0bad_f00d, 4'h0, 32'h0},  // Data region
      '{kFabRd, 32'h0001_0100, 32'h0,         4'h0, 32'h0},
      '{kFabRd, 32'h0000_0044, 32'h0,         4'h0, 32'h0},
      '{kFabRd, 32'h0005_0000, 32'h0,         4'h0, 32'h0},  // Unmapped
      '{kRemSt, 32'h0701_0101, 32'hdead_beef, 4'hf, 32'h0055_1234},  // Same word, other tile
      '{kRemLd, 32'h0902_0010, 32'h0,         4'h0, 32'h0},
      '{kBurst, 32'h0,         32'd6,         4'h0, 32'h0}
   };

   tileMemWrap u_tileMemWrap (.*);

   bind tileMemWrap tileMem_checker u_tileMemChecker (
      .Clock (Clock), .rstN (rstN), .localTileId (localTileId),
      .dMemAddressQ103H (dMemAddressQ103H), .dMemRdEnQ103H (dMemRdEnQ103H),
      .dMemReady (dMemReady), .outFabricValid (outFabricValid), .fabReady (fabReady)
   );

   initial begin
      Clock = 1'b0;
      forever #2 Clock = ~Clock;
   end

   // Watchdog, 50 cycles per step plus reset
   initial begin
      repeat (16 + 50 * nSteps) @(posedge Clock);
      $display("Timeout: the test steps did not complete in the allowed cycles");
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
   end

   always @(posedge Clock) begin
      if (rstN && outFabricValid) seen.push_back(outFabric);  // Transfer this edge
   end

   // ============================================================
   // Helpers
   // ============================================================
   task automatic compareValues(input string name, input logic [73:0] want,
         input logic [73:0] got);
      if (got !== want) begin
         $display("** Error: %s expected %h actual %h", name, want, got);
         $display("SIMULATION FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic tileMemPkg::tTileTrans makeTrans(input logic [31:0] a,
         input logic [31:0] d, input tileMemPkg::tOpcode op, input logic [7:0] id);
      return '{address: a, data: d, opcode: op, requestorId: id};
   endfunction

   task automatic driveCore(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be,
         input logic wr, input logic rd);
      dMemAddressQ103H = a;
      dMemWrDataQ103H  = d;
      dMemByteEnQ103H  = be;
      dMemWrEnQ103H    = wr;
      dMemRdEnQ103H    = rd;
   endtask

   task automatic driveFabric(input logic v, input tileMemPkg::tTileTrans t);
      inFabricValid = v;
      inFabric      = t;
   endtask

   // Enables shift with the offset, lanes past 3 fall off
   task automatic storeModel(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
      int off;
      off = a[1:0];
      for (int j = off; j < 4; j++) begin
         if (be[j - off]) dModel[{a[11:2], 2'(j)}] = d[8 * (j - off) +: 8];
      end
   endtask

   function automatic logic [31:0] modelWord(input logic [31:0] a);
      if (a[23:16] == 8'h00) return iModel[a[11:2]];
      if (a[23:16] == 8'h01) return {dModel[{a[11:2], 2'd3}], dModel[{a[11:2], 2'd2}],
                                     dModel[{a[11:2], 2'd1}], dModel[{a[11:2], 2'd0}]};
      return '0;
   endfunction

   task automatic nextOut(output tileMemPkg::tTileTrans t);
      while (seen.size() == 0) @(negedge Clock);
      t = seen.pop_front();
   endtask

   // ============================================================
   // Back-pressure burst, fabric reads against remote stores
   // ============================================================
   task automatic runBurst(input int n);
      tileMemPkg::tTileTrans rspExp [$];
      tileMemPkg::tTileTrans reqExp [$];
      tileMemPkg::tTileTrans got;
      logic [31:0]           a;
      logic [31:0]           d;
      int                    nRd;
      int                    nSt;
      nRd = 0;
      nSt = 0;
      while (nRd < n || nSt < n || seen.size() < 2 * n) begin
         fabReady = 1'($urandom);
         driveFabric(1'b0, '0);
         driveCore('0, '0, '0, 1'b0, 1'b0);
         if (nRd < n && tileReady) begin
            a = nRd[0] ? 32'h0001_0200 : 32'h0001_0100;
            driveFabric(1'b1, makeTrans(a, '0, tileMemPkg::rd, peerId));
            rspExp.push_back(makeTrans({peerId, a[23:0]}, modelWord(a), tileMemPkg::rdRsp, myId));
            nRd++;
         end
         if (nSt < n && dMemReady) begin
            a = 32'h0b00_0000 | (nSt << 2);
            d = $urandom;
            driveCore(a, d, 4'hf, 1'b1, 1'b0);
            reqExp.push_back(makeTrans(a, d, tileMemPkg::wr, myId));
            nSt++;
         end
         @(negedge Clock);
      end
      fabReady = 1'b1;
      driveFabric(1'b0, '0);
      driveCore('0, '0, '0, 1'b0, 1'b0);
      repeat (4) @(negedge Clock);   // Any duplicate would show up here
      compareValues("burst count", 2 * n, seen.size());
      while (seen.size() > 0) begin
         got = seen.pop_front();
         if (got.opcode == tileMemPkg::rdRsp) compareValues("burst rsp", rspExp.pop_front(), got);
         else compareValues("burst req", reqExp.pop_front(), got);
      end
   endtask

   task automatic runStep(input tStep s, input string name);
      tileMemPkg::tTileTrans got;
      logic [31:0]           want;
      logic [31:0]           rnd;
      case (s.kind)
         kSt, kRemSt: begin
            driveCore(s.addr, s.data, s.be, 1'b1, 1'b0);
            @(negedge Clock);
            if (s.kind == kSt) begin
               storeModel(s.addr, s.data, s.be);
            end else begin
               driveCore('0, '0, '0, 1'b0, 1'b0);
               nextOut(got);
               compareValues(name, makeTrans(s.addr, s.data, tileMemPkg::wr, myId), got);
            end
            driveCore({8'h00, s.addr[23:0]}, '0, 4'hf, 1'b0, 1'b1);  // Local load back
            @(negedge Clock);
            driveCore('0, '0, '0, 1'b0, 1'b0);
            @(negedge Clock);
            compareValues({name, " load"}, s.exp, dMemRdRspQ105H);
         end
         kFabWr: begin
            driveFabric(1'b1, makeTrans(s.addr, s.data, tileMemPkg::wr, peerId));
            @(negedge Clock);
            driveFabric(1'b0, '0);
            if (s.addr[23:16] == 8'h00) iModel[s.addr[11:2]] = s.data;
            else storeModel({s.addr[31:2], 2'b00}, s.data, 4'hf);
         end
         kFetch: begin
            want    = iModel[s.addr[11:2]];
            pcQ100H = s.addr;
            @(negedge Clock);
            compareValues(name, want, instructionQ101H);
            readyQ101H = 1'b0;             // Core stalls, fetch moves on
            pcQ100H    = s.addr ^ 32'h4;
            @(negedge Clock);
            compareValues({name, " hold"}, want, instructionQ101H);
            readyQ101H = 1'b1;
         end
         kFabRd: begin
            driveFabric(1'b1, makeTrans(s.addr, '0, tileMemPkg::rd, peerId));
            @(negedge Clock);
            driveFabric(1'b0, '0);
            nextOut(got);
            compareValues(name, makeTrans({peerId, s.addr[23:0]}, modelWord(s.addr),
                                          tileMemPkg::rdRsp, myId), got);
         end
         kRemLd: begin
            rnd = $urandom;
            driveCore(s.addr, '0, 4'hf, 1'b0, 1'b1);
            @(negedge Clock);
            driveCore('0, '0, '0, 1'b0, 1'b0);
            compareValues({name, " stall"}, 1'b0, dMemReady);
            nextOut(got);
            compareValues(name, makeTrans(s.addr, '0, tileMemPkg::rd, myId), got);
            driveFabric(1'b1, makeTrans({myId, 24'h0}, rnd, tileMemPkg::rdRsp, 8'h09));
            @(negedge Clock);
            driveFabric(1'b0, '0);
            @(negedge Clock);
            compareValues({name, " data"}, rnd, dMemRdRspQ105H);
            compareValues({name, " ready"}, 1'b1, dMemReady);
         end
         default: runBurst(s.data);
      endcase
   endtask

   // ============================================================
   // Main sequence
   // ============================================================
   initial begin
      void'($urandom(32'h8e92));
      rstN        = 1'b0;
      localTileId = myId;
      readyQ101H  = 1'b1;
      pcQ100H     = '0;
      fabReady    = 1'b1;
      driveCore('0, '0, '0, 1'b0, 1'b0);
      driveFabric(1'b0, '0);
      repeat (16) @(negedge Clock);
      rstN = 1'b1;
      @(negedge Clock);
      compareValues("reset ready", 2'b11, {dMemReady, tileReady});
      for (int i = 0; i < nSteps; i++) begin
         runStep(steps[i], $sformatf("step %0d", i));
      end
      @(negedge Clock);
      if (seen.size() != 0) begin
         $display("Unexpected transactions left on the outgoing fabric bus");
         $display("SIMULATION FAILED");
         $fatal(1, "leftover fabric traffic");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

// ==== all.f ====
hw/tileMemPkg.sv
hw/dualPortRam.sv
hw/transFifo.sv
hw/rrArbiter.sv
hw/fabricTarget.sv
hw/coreDataPort.sv
hw/tileMemWrap.sv
testbench/tileMem_checker.sv
testbench/tileMemTb.sv

// ==== Makefile ====
# Verilator build and run of the tile memory testbench

VERILATOR ?= verilator
TOP       ?= tileMemTb
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJDIR    ?= obj_dir

.PHONY: sim clean

# A $fatal in the run gives a nonzero exit status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f all.f
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
